// File: design/bus_pkg.sv
// Shared address map, sizes and enums of the memory-bus subsystem.
// Single full-speed clock only. FLASH_WAIT must be at least 2.
// DMA source and destination are word indices, not byte addresses.
package bus_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // work RAM at byte 0x0000..0x0fff
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;

    // flash window ends at 0xbfff
    localparam logic [ADDR_W-1:0] FLASH_BASE  = 16'h8000;
    localparam int                FLASH_WORDS = 4096;
    localparam int                FLASH_AW    = 12;
    localparam int                FLASH_WAIT  = 5;
    localparam int                FLASH_CNT_W = $clog2(FLASH_WAIT);
    localparam logic [DATA_W-1:0] FLASH_MUL   = 32'h9E3779B1;

    localparam logic [ADDR_W-1:0] PERIPH_BASE = 16'hF000;
    localparam logic [15:0]       STATUS_ID   = 16'hB05A;

    // word count, wide enough for a full RAM copy
    localparam int DMA_LEN_W = RAM_AW + 1;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_FLASH,
        REGION_PERIPH
    } region_t;

    typedef enum logic [2:0] {
        PREG_NONE,
        PREG_STATUS,
        PREG_PAD,
        PREG_DMA_SRC,
        PREG_DMA_DST,
        PREG_DMA_LEN,
        PREG_DMA_GO
    } preg_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_READ,
        DMA_WRITE
    } dma_state_t;

endpackage

// File: design/address_decoder.sv
// Purely combinational address decode of the CPU byte address.
// Low two address bits are ignored for peripheral register selection.
module address_decoder (
    input  logic [bus_pkg::ADDR_W-1:0] cpu_addr,
    output bus_pkg::region_t           region,
    output bus_pkg::preg_t             preg
);
    import bus_pkg::*;

    logic [ADDR_W-1:0] offset;
    logic [ADDR_W-1:0] word_off;

    // offset into the peripheral window, word aligned
    assign offset   = cpu_addr - PERIPH_BASE;
    assign word_off = {offset[ADDR_W-1:2], 2'b00};

    always_comb begin
        region = REGION_NONE;
        preg   = PREG_NONE;
        if (cpu_addr < ADDR_W'(RAM_WORDS * 4)) begin
            region = REGION_RAM;
        end else if (cpu_addr >= FLASH_BASE &&
                     cpu_addr <= ADDR_W'(FLASH_BASE + FLASH_WORDS * 4 - 1)) begin
            region = REGION_FLASH;
        end else if (cpu_addr >= PERIPH_BASE) begin
            region = REGION_PERIPH;
            case (word_off)
                ADDR_W'('h00): preg = PREG_STATUS;
                ADDR_W'('h04): preg = PREG_PAD;
                ADDR_W'('h10): preg = PREG_DMA_SRC;
                ADDR_W'('h14): preg = PREG_DMA_DST;
                ADDR_W'('h18): preg = PREG_DMA_LEN;
                ADDR_W'('h1C): preg = PREG_DMA_GO;
                // holes in the window read as zero
                default:       preg = PREG_NONE;
            endcase
        end
    end

endmodule

// File: design/bus_arbiter.sv
// RAM ownership between CPU and DMA, CPU ready generation and read steering.
// The CPU must hold its request stable until it sees the one-cycle ready.
// Flash writes are not supported and complete like unmapped writes.
module bus_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_valid,
    input  logic [bus_pkg::ADDR_W-1:0]  cpu_addr,
    input  logic [bus_pkg::DATA_W-1:0]  cpu_wdata,
    input  logic [bus_pkg::STRB_W-1:0]  cpu_wstrb,
    input  bus_pkg::region_t            region,
    input  logic                        dma_busy,
    input  logic                        dma_ram_we,
    input  logic [bus_pkg::RAM_AW-1:0]  dma_ram_addr,
    input  logic [bus_pkg::DATA_W-1:0]  dma_ram_wdata,
    input  logic                        flash_ready,
    input  logic                        flash_for_dma,
    input  logic [bus_pkg::DATA_W-1:0]  flash_rdata,
    input  logic [bus_pkg::DATA_W-1:0]  ram_rdata,
    input  logic [bus_pkg::DATA_W-1:0]  periph_rdata,
    output logic                        cpu_ready,
    output logic [bus_pkg::DATA_W-1:0]  cpu_rdata,
    output logic                        ram_cs,
    output logic                        ram_we,
    output logic [bus_pkg::RAM_AW-1:0]  ram_addr,
    output logic [bus_pkg::DATA_W-1:0]  ram_wdata,
    output logic [bus_pkg::STRB_W-1:0]  ram_wstrb,
    output logic                        cpu_flash_req,
    output logic                        periph_wr,
    output logic                        periph_rd
);
    import bus_pkg::*;

    logic    start;
    logic    is_write;
    logic    flash_rd;
    logic    cpu_flash_done;
    logic    flash_pend;
    region_t region_q;

    assign is_write       = |cpu_wstrb;
    assign flash_rd       = (region == REGION_FLASH) && !is_write;
    assign cpu_flash_done = flash_ready && !flash_for_dma;

    // first cycle of a CPU request, never while DMA owns the bus
    assign start = cpu_valid && !dma_busy && !cpu_ready && !flash_pend;

    // DMA always writes whole words
    assign ram_cs    = dma_busy ? dma_ram_we : (start && region == REGION_RAM);
    assign ram_we    = dma_busy ? dma_ram_we : (start && region == REGION_RAM && is_write);
    assign ram_addr  = dma_busy ? dma_ram_addr : cpu_addr[RAM_AW+1:2];
    assign ram_wdata = dma_busy ? dma_ram_wdata : cpu_wdata;
    assign ram_wstrb = dma_busy ? '1 : cpu_wstrb;

    assign cpu_flash_req = start && flash_rd;
    assign periph_wr     = start && region == REGION_PERIPH && is_write;
    assign periph_rd     = start && region == REGION_PERIPH && !is_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_ready  <= 1'b0;
            flash_pend <= 1'b0;
            region_q   <= REGION_NONE;
        end else begin
            if (start) begin
                region_q <= region;
            end
            if (cpu_flash_req) begin
                flash_pend <= 1'b1;
            end else if (cpu_flash_done) begin
                flash_pend <= 1'b0;
            end
            if (dma_busy) begin
                cpu_ready <= 1'b0;
            end else begin
                cpu_ready <= (start && !flash_rd) || cpu_flash_done;
            end
        end
    end

    // unmapped reads return zero
    always_comb begin
        case (region_q)
            REGION_RAM:    cpu_rdata = ram_rdata;
            REGION_FLASH:  cpu_rdata = flash_rdata;
            REGION_PERIPH: cpu_rdata = periph_rdata;
            default:       cpu_rdata = '0;
        endcase
    end

endmodule

// File: design/work_ram.sv
// Single-port work RAM with byte strobes and one-cycle registered read.
// Contents are undefined after power-up.
module work_ram (
    input  logic                        clk,
    input  logic                        ram_cs,
    input  logic                        ram_we,
    input  logic [bus_pkg::RAM_AW-1:0]  ram_addr,
    input  logic [bus_pkg::DATA_W-1:0]  ram_wdata,
    input  logic [bus_pkg::STRB_W-1:0]  ram_wstrb,
    output logic [bus_pkg::DATA_W-1:0]  ram_rdata
);
    import bus_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (ram_cs) begin
            if (ram_we) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (ram_wstrb[i]) begin
                        mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
                    end
                end
            end
            // old contents on a write cycle
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// File: design/flash_rom.sv
// Read-only flash model, word i holds i * FLASH_MUL.
// One access at a time; requests while busy are dropped.
// DMA wins when both ports request in the same cycle.
module flash_rom (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cpu_flash_req,
    input  logic [bus_pkg::FLASH_AW-1:0] cpu_flash_addr,
    input  logic                         dma_flash_req,
    input  logic [bus_pkg::FLASH_AW-1:0] dma_flash_addr,
    output logic                         flash_ready,
    output logic                         flash_for_dma,
    output logic [bus_pkg::DATA_W-1:0]   flash_rdata
);
    import bus_pkg::*;

    logic                   busy;
    logic [FLASH_CNT_W-1:0] cnt;
    logic [FLASH_AW-1:0]    addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy          <= 1'b0;
            cnt           <= '0;
            flash_ready   <= 1'b0;
            flash_for_dma <= 1'b0;
        end else begin
            flash_ready <= 1'b0;
            if (!busy) begin
                // ready lands FLASH_WAIT cycles after the request
                if (dma_flash_req || cpu_flash_req) begin
                    busy          <= 1'b1;
                    cnt           <= FLASH_CNT_W'(FLASH_WAIT - 2);
                    flash_for_dma <= dma_flash_req;
                end
            end else if (cnt == '0) begin
                busy        <= 1'b0;
                flash_ready <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // address and data are payload
    always_ff @(posedge clk) begin
        if (!busy && (dma_flash_req || cpu_flash_req)) begin
            addr_q <= dma_flash_req ? dma_flash_addr : cpu_flash_addr;
        end
        if (busy && cnt == '0) begin
            flash_rdata <= {{(DATA_W-FLASH_AW){1'b0}}, addr_q} * FLASH_MUL;
        end
    end

endmodule

// File: design/dma_engine.sv
// Copies dma_len flash words starting at word dma_src into RAM at word dma_dst.
// Each word takes FLASH_WAIT + 2 cycles. A zero length start is ignored.
module dma_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dma_go,
    input  logic [bus_pkg::FLASH_AW-1:0]  dma_src,
    input  logic [bus_pkg::RAM_AW-1:0]    dma_dst,
    input  logic [bus_pkg::DMA_LEN_W-1:0] dma_len,
    input  logic                          flash_ready,
    input  logic                          flash_for_dma,
    input  logic [bus_pkg::DATA_W-1:0]    flash_rdata,
    output logic                          dma_busy,
    output logic                          dma_done,
    output logic                          dma_flash_req,
    output logic [bus_pkg::FLASH_AW-1:0]  dma_flash_addr,
    output logic                          dma_ram_we,
    output logic [bus_pkg::RAM_AW-1:0]    dma_ram_addr,
    output logic [bus_pkg::DATA_W-1:0]    dma_ram_wdata
);
    import bus_pkg::*;

    dma_state_t           state;
    logic [FLASH_AW-1:0]  src_q;
    logic [RAM_AW-1:0]    dst_q;
    logic [DMA_LEN_W-1:0] remain;
    logic [DATA_W-1:0]    data_q;

    assign dma_busy       = (state != DMA_IDLE);
    assign dma_flash_addr = src_q;
    assign dma_ram_we     = (state == DMA_WRITE);
    assign dma_ram_addr   = dst_q;
    assign dma_ram_wdata  = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= DMA_IDLE;
            src_q         <= '0;
            dst_q         <= '0;
            remain        <= '0;
            dma_flash_req <= 1'b0;
            dma_done      <= 1'b0;
        end else begin
            dma_flash_req <= 1'b0;
            dma_done      <= 1'b0;
            case (state)
                DMA_IDLE: begin
                    if (dma_go && dma_len != '0) begin
                        src_q         <= dma_src;
                        dst_q         <= dma_dst;
                        remain        <= dma_len;
                        dma_flash_req <= 1'b1;
                        state         <= DMA_READ;
                    end
                end
                DMA_READ: begin
                    // only answers tagged for this port
                    if (flash_ready && flash_for_dma) begin
                        state <= DMA_WRITE;
                    end
                end
                DMA_WRITE: begin
                    if (remain == DMA_LEN_W'(1)) begin
                        dma_done <= 1'b1;
                        state    <= DMA_IDLE;
                    end else begin
                        remain        <= remain - 1'b1;
                        src_q         <= src_q + 1'b1;
                        dst_q         <= dst_q + 1'b1;
                        dma_flash_req <= 1'b1;
                        state         <= DMA_READ;
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DMA_READ && flash_ready && flash_for_dma) begin
            data_q <= flash_rdata;
        end
    end

endmodule

// File: design/periph_regs.sv
// Status, gamepad and DMA control registers.
// DMA registers keep only their used low bits and read back zero-extended.
// Writing any value to the go register starts a copy.
module periph_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          periph_wr,
    input  logic                          periph_rd,
    input  bus_pkg::preg_t                preg,
    input  logic [bus_pkg::DATA_W-1:0]    cpu_wdata,
    input  logic [1:0]                    pad,
    input  logic                          dma_busy,
    input  logic                          dma_done,
    output logic [bus_pkg::DATA_W-1:0]    periph_rdata,
    output logic [bus_pkg::FLASH_AW-1:0]  dma_src,
    output logic [bus_pkg::RAM_AW-1:0]    dma_dst,
    output logic [bus_pkg::DMA_LEN_W-1:0] dma_len,
    output logic                          dma_go
);
    import bus_pkg::*;

    logic [1:0] pad_q;
    logic [7:0] done_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            pad_q    <= '0;
            done_cnt <= '0;
            dma_src  <= '0;
            dma_dst  <= '0;
            dma_len  <= '0;
            dma_go   <= 1'b0;
        end else begin
            pad_q  <= pad;
            dma_go <= 1'b0;
            // wraps after 255 copies
            if (dma_done) begin
                done_cnt <= done_cnt + 1'b1;
            end
            if (periph_wr) begin
                case (preg)
                    PREG_DMA_SRC: dma_src <= cpu_wdata[FLASH_AW-1:0];
                    PREG_DMA_DST: dma_dst <= cpu_wdata[RAM_AW-1:0];
                    PREG_DMA_LEN: dma_len <= cpu_wdata[DMA_LEN_W-1:0];
                    PREG_DMA_GO:  dma_go  <= 1'b1;
                    default:      ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (periph_rd) begin
            case (preg)
                PREG_STATUS:  periph_rdata <= {STATUS_ID, 7'd0, dma_busy, done_cnt};
                PREG_PAD:     periph_rdata <= DATA_W'(pad_q);
                PREG_DMA_SRC: periph_rdata <= DATA_W'(dma_src);
                PREG_DMA_DST: periph_rdata <= DATA_W'(dma_dst);
                PREG_DMA_LEN: periph_rdata <= DATA_W'(dma_len);
                default:      periph_rdata <= '0;
            endcase
        end
    end

endmodule

// File: design/bus_subsystem.sv
// Top level of the memory-bus subsystem, wiring only.
// CPU handshake: hold the request until the one-cycle cpu_ready.
module bus_subsystem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_valid,
    input  logic [bus_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [bus_pkg::DATA_W-1:0] cpu_wdata,
    input  logic [bus_pkg::STRB_W-1:0] cpu_wstrb,
    input  logic [1:0]                 pad,
    output logic                       cpu_ready,
    output logic [bus_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       dma_busy
);
    import bus_pkg::*;

    region_t              region;
    preg_t                preg;
    logic                 ram_cs;
    logic                 ram_we;
    logic [RAM_AW-1:0]    ram_addr;
    logic [DATA_W-1:0]    ram_wdata;
    logic [STRB_W-1:0]    ram_wstrb;
    logic [DATA_W-1:0]    ram_rdata;
    logic                 cpu_flash_req;
    logic [FLASH_AW-1:0]  cpu_flash_addr;
    logic                 dma_flash_req;
    logic [FLASH_AW-1:0]  dma_flash_addr;
    logic                 flash_ready;
    logic                 flash_for_dma;
    logic [DATA_W-1:0]    flash_rdata;
    logic                 periph_wr;
    logic                 periph_rd;
    logic [DATA_W-1:0]    periph_rdata;
    logic [FLASH_AW-1:0]  dma_src;
    logic [RAM_AW-1:0]    dma_dst;
    logic [DMA_LEN_W-1:0] dma_len;
    logic                 dma_go;
    logic                 dma_done;
    logic                 dma_ram_we;
    logic [RAM_AW-1:0]    dma_ram_addr;
    logic [DATA_W-1:0]    dma_ram_wdata;

    // flash window is aligned, so the word index is a plain slice
    assign cpu_flash_addr = cpu_addr[FLASH_AW+1:2];

    address_decoder address_decoder_inst (.*);
    bus_arbiter     bus_arbiter_inst     (.*);
    work_ram        work_ram_inst        (.*);
    flash_rom       flash_rom_inst       (.*);
    dma_engine      dma_engine_inst      (.*);
    periph_regs     periph_regs_inst     (.*);

endmodule

// File: tb/tb_clock.sv
// Free-running testbench clock, period 4 time units.
// Starts low at time zero.
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

// File: tb/tb_bus_subsystem.sv
// Directed tests of the memory-bus subsystem through its CPU port.
// Inputs change on falling edges and outputs are sampled on falling edges.
// The run stops at the first mismatch or missing handshake.
module tb_bus_subsystem;
    import bus_pkg::*;

    localparam int RESET_CYCLES    = 3;
    localparam int ACCESS_CYCLES   = FLASH_WAIT + 3;
    localparam int DMA_WORDS       = 6;
    localparam int DMA_CYCLES      = DMA_WORDS * (FLASH_WAIT + 2) + 4;
    localparam int MAX_ACCESSES    = 150;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + MAX_ACCESSES * ACCESS_CYCLES + DMA_CYCLES);

    logic              clk;
    logic              rst;
    logic              cpu_valid;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_wdata;
    logic [STRB_W-1:0] cpu_wstrb;
    logic [1:0]        pad;
    logic              cpu_ready;
    logic [DATA_W-1:0] cpu_rdata;
    logic              dma_busy;

    // reference models
    logic [DATA_W-1:0] ram_model [RAM_WORDS];
    logic [7:0]        done_model;
    logic [DATA_W-1:0] lcg_state;

    tb_clock tb_clock_inst (.clk(clk));

    bus_subsystem bus_subsystem_inst (.*);

    function automatic logic [DATA_W-1:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // flash word i holds i times the multiplier
    function automatic logic [DATA_W-1:0] flash_model(input int idx);
        return DATA_W'(idx) * FLASH_MUL;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
            input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
            input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            fail_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // one request held until cpu_ready, latency counted in cycles
    task automatic cpu_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
            input logic [STRB_W-1:0] wstrb, input int max_cycles,
            output logic [DATA_W-1:0] rdata, output int cycles, output int busy_cycles);
        @(negedge clk);
        cpu_valid   = 1'b1;
        cpu_addr    = addr;
        cpu_wdata   = wdata;
        cpu_wstrb   = wstrb;
        cycles      = 0;
        busy_cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (dma_busy) begin
                busy_cycles++;
            end
        end while (!cpu_ready && cycles < max_cycles);
        if (!cpu_ready) begin
            fail_run($sformatf("cpu_ready for address %h missing after %0d cycles",
                addr, max_cycles));
        end
        rdata     = cpu_rdata;
        cpu_valid = 1'b0;
        cpu_wstrb = '0;
    endtask

    task automatic timed_access(input string name, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb,
            input int exp_cycles, output logic [DATA_W-1:0] rdata);
        int cycles;
        int busy_cycles;
        cpu_access(addr, wdata, wstrb, ACCESS_CYCLES, rdata, cycles, busy_cycles);
        check_latency(name, exp_cycles, cycles);
    endtask

    task automatic read_expect(input string name, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] expected, input int exp_cycles);
        logic [DATA_W-1:0] rdata;
        timed_access(name, addr, '0, '0, exp_cycles, rdata);
        check_data(name, expected, rdata);
    endtask

    task automatic reg_write(input string name, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] rdata;
        timed_access(name, addr, data, 4'hF, 1, rdata);
    endtask

    task automatic ram_write(input string name, input logic [RAM_AW-1:0] word,
            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] rdata;
        timed_access(name, ADDR_W'({word, 2'b00}), data, strb, 1, rdata);
        ram_model[word] = merge_bytes(ram_model[word], data, strb);
    endtask

    task automatic ram_read(input string name, input logic [RAM_AW-1:0] word);
        read_expect(name, ADDR_W'({word, 2'b00}), ram_model[word], 1);
    endtask

    task automatic ram_word_roundtrip();
        ram_write("ram_word", 10'h025, 32'hDEADBEEF, 4'hF);
        ram_read("ram_word", 10'h025);
        ram_write("ram_word", 10'h3FF, 32'h0BADF00D, 4'hF);
        ram_read("ram_word", 10'h3FF);
    endtask

    task automatic byte_strobe_merge();
        logic [STRB_W-1:0] strbs [4];
        logic [DATA_W-1:0] datas [4];
        strbs = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        // every byte differs from what the word holds before each write
        datas = '{32'hA5C3E1F0, 32'h5A3C1E0F, 32'hC3A5F0E1, 32'h0F1E3C5A};
        ram_write("byte_strobe", 10'h040, 32'h11223344, 4'hF);
        for (int i = 0; i < 4; i++) begin
            ram_write("byte_strobe", 10'h040, datas[i], strbs[i]);
            ram_read("byte_strobe", 10'h040);
        end
    endtask

    task automatic flash_read_sweep();
        int idx [5];
        idx = '{0, 1, 7, 341, FLASH_WORDS - 1};
        for (int i = 0; i < 5; i++) begin
            read_expect("flash_read", FLASH_BASE + ADDR_W'(idx[i] * 4), flash_model(idx[i]),
                FLASH_WAIT + 1);
        end
    endtask

    task automatic periph_register_reads();
        read_expect("status", PERIPH_BASE, {STATUS_ID, 7'd0, 1'b0, done_model}, 1);
        pad = 2'b10;
        read_expect("pad", PERIPH_BASE + 16'h4, 32'h2, 1);
        pad = 2'b01;
        read_expect("pad", PERIPH_BASE + 16'h4, 32'h1, 1);
        reg_write("dma_src", PERIPH_BASE + 16'h10, 32'h0ABC);
        read_expect("dma_src", PERIPH_BASE + 16'h10, 32'h0ABC, 1);
        reg_write("dma_dst", PERIPH_BASE + 16'h14, 32'h02A5);
        read_expect("dma_dst", PERIPH_BASE + 16'h14, 32'h02A5, 1);
        reg_write("dma_len", PERIPH_BASE + 16'h18, 32'h0123);
        read_expect("dma_len", PERIPH_BASE + 16'h18, 32'h0123, 1);
        read_expect("unmapped", 16'h4000, '0, 1);
        read_expect("periph_hole", PERIPH_BASE + 16'h8, '0, 1);
    endtask

    task automatic dma_copy_with_stall();
        logic [DATA_W-1:0] rdata;
        logic [RAM_AW-1:0] dst;
        int                src;
        int                cycles;
        int                busy_cycles;
        src = 'h200;
        dst = 10'h300;
        reg_write("dma_setup", PERIPH_BASE + 16'h10, DATA_W'(src));
        reg_write("dma_setup", PERIPH_BASE + 16'h14, DATA_W'(dst));
        reg_write("dma_setup", PERIPH_BASE + 16'h18, DATA_W'(DMA_WORDS));
        reg_write("dma_setup", PERIPH_BASE + 16'h1C, 32'h1);
        cycles = 0;
        while (!dma_busy && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        check_busy("dma_busy_rise", 1'b1, dma_busy);
        // RAM read of the last word, stalled behind the copy
        cpu_access(ADDR_W'({dst + RAM_AW'(DMA_WORDS - 1), 2'b00}), '0, '0,
            DMA_CYCLES + ACCESS_CYCLES, rdata, cycles, busy_cycles);
        check_busy("dma_stall_seen", 1'b1, busy_cycles > 0);
        check_latency("dma_stall", busy_cycles + 2, cycles);
        check_busy("dma_busy_fall", 1'b0, dma_busy);
        for (int i = 0; i < DMA_WORDS; i++) begin
            ram_model[dst + RAM_AW'(i)] = flash_model(src + i);
        end
        check_data("dma_stall", ram_model[dst + RAM_AW'(DMA_WORDS - 1)], rdata);
        for (int i = 0; i < DMA_WORDS; i++) begin
            ram_read("dma_copy", dst + RAM_AW'(i));
        end
        done_model++;
        read_expect("dma_status", PERIPH_BASE, {STATUS_ID, 7'd0, 1'b0, done_model}, 1);
    endtask

    task automatic random_ram_traffic();
        logic [DATA_W-1:0] r;
        logic [RAM_AW-1:0] w;
        // 16-word window, filled first
        for (int i = 0; i < 16; i++) begin
            ram_write("random_fill", 10'h100 + RAM_AW'(i), next_random(), 4'hF);
        end
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            w = 10'h100 + RAM_AW'(r[19:16]);
            if (r[27:24] == 4'h0) begin
                ram_read("random_read", w);
            end else begin
                ram_write("random_write", w, next_random(), r[27:24]);
            end
            r = next_random();
            ram_read("random_read", 10'h100 + RAM_AW'(r[23:20]));
        end
    endtask

    initial begin
        rst        = 1'b1;
        cpu_valid  = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_wstrb  = '0;
        pad        = '0;
        done_model = '0;
        lcg_state  = 32'd44213;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_busy("reset_dma_busy", 1'b0, dma_busy);
        check_busy("reset_cpu_ready", 1'b0, cpu_ready);
        ram_word_roundtrip();
        byte_strobe_merge();
        flash_read_sweep();
        periph_register_reads();
        dma_copy_with_stall();
        random_ram_traffic();
        $display("ALL TESTS PASSED");
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

// File: files.f
design/bus_pkg.sv
design/address_decoder.sv
design/bus_arbiter.sv
design/work_ram.sv
design/flash_rom.sv
design/dma_engine.sv
design/periph_regs.sv
design/bus_subsystem.sv
tb/tb_clock.sv
tb/tb_bus_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bus subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_bus_subsystem -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
